// File: Makefile
SIM_LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f arm_lite_core.f --top-module tb_arm_lite_core \
		-Mdir obj_dir -o sim_arm_lite_core

run: compile
	./obj_dir/sim_arm_lite_core | tee $(SIM_LOG)
	@if grep -q "Some tests failed" $(SIM_LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All tests passed" $(SIM_LOG); then \
		echo "simulation did not finish"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(SIM_LOG)

// File: arm_lite_core.f
+incdir+sim
logic/arm_lite_pkg.sv
logic/decoded_if.sv
logic/reg_if.sv
logic/ins_decoder.sv
logic/reg_bank.sv
logic/operand2_shifter.sv
logic/execute_stage.sv
logic/arm_lite_core.sv
sim/tb_arm_lite_core.sv

// File: logic/arm_lite_core.sv
// top level of the arm lite core, instruction strobe in and writeback report out
`timescale 1ns/1ps

module arm_lite_core (
    input  logic                    clk,
    input  logic                    i_reset_n,
    input  logic                    i_ins_valid,
    input  arm_lite_pkg::word_t     i_ins,
    output logic                    o_wb_valid,
    output logic                    o_wb_en,
    output arm_lite_pkg::reg_addr_t o_wb_addr,
    output arm_lite_pkg::word_t     o_wb_data,
    output arm_lite_pkg::nzcv_t     o_nzcv
);
    decoded_if u_dec_if ();  // decoder to execute, one cycle after the strobe
    reg_if     u_rf_if ();

    ins_decoder u_ins_decoder (
        .clk        (clk),
        .i_reset_n  (i_reset_n),
        .i_ins_valid(i_ins_valid),
        .i_ins      (i_ins),
        .o_dec      (u_dec_if.dec_out)
    );

    reg_bank u_reg_bank (
        .clk      (clk),
        .i_reset_n(i_reset_n),
        .io_rf    (u_rf_if.bank)
    );

    // writeback report lands two cycles after the strobe
    execute_stage u_execute_stage (
        .clk       (clk),
        .i_reset_n (i_reset_n),
        .i_dec     (u_dec_if.exe_in),
        .io_rf     (u_rf_if.user),
        .o_wb_valid(o_wb_valid),
        .o_wb_en   (o_wb_en),
        .o_wb_addr (o_wb_addr),
        .o_wb_data (o_wb_data),
        .o_nzcv    (o_nzcv)
    );
endmodule

// File: logic/arm_lite_pkg.sv
// shared widths, instruction field positions and types of the arm lite core, compiled first
package arm_lite_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 4;
    localparam int NUM_REGS   = 16;

    // data-processing instruction fields
    localparam int COND_LSB      = 28;
    localparam int TYPE_LSB      = 26;  // 2-bit instruction class
    localparam int IMM_BIT       = 25;
    localparam int OPC_LSB       = 21;
    localparam int S_BIT         = 20;
    localparam int RN_LSB        = 16;
    localparam int RD_LSB        = 12;
    localparam int ROT_LSB       = 8;   // immediate form
    localparam int IMM8_LSB      = 0;
    localparam int SHAMT_LSB     = 7;   // register form
    localparam int SHIFT_LSB     = 5;
    localparam int REG_SHIFT_BIT = 4;   // set for register-specified shifts
    localparam int RM_LSB        = 0;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]            nzcv_t;  // {n, z, c, v}

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL, COND_NV
    } cond_e;

    // only the supported opcodes, everything else decodes as a no-op
    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_EOR = 4'b0001,
        OP_SUB = 4'b0010,
        OP_ADD = 4'b0100,
        OP_TST = 4'b1000,
        OP_CMP = 4'b1010,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101,
        OP_MVN = 4'b1111
    } dp_op_e;

    typedef enum logic [2:0] {
        ALU_PASS_B, ALU_NOT_B, ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_EOR
    } alu_op_e;

    typedef enum logic [1:0] {SH_LSL, SH_LSR, SH_ASR, SH_ROR} shift_e;

    typedef struct packed {
        logic       is_imm;
        logic [7:0] imm8;
        logic [3:0] rot4;    // rotate right by twice this
        shift_e     sh;
        logic [4:0] shamt5;  // zero means no shift
        reg_addr_t  rm;
    } operand2_t;

endpackage

// File: logic/decoded_if.sv
// carries one decoded instruction per valid strobe from the decoder to the execute stage
`timescale 1ns/1ps

interface decoded_if ();
    import arm_lite_pkg::*;

    logic      valid;      // one-cycle strobe, never stalled
    cond_e     cond;
    alu_op_e   alu_op;
    logic      wb_en;      // low for no-ops, cmp and tst
    logic      set_flags;
    reg_addr_t rd;
    reg_addr_t rn;
    operand2_t op2;

    modport dec_out (
        output valid, cond, alu_op, wb_en, set_flags, rd, rn, op2
    );

    modport exe_in (
        input valid, cond, alu_op, wb_en, set_flags, rd, rn, op2
    );
endinterface

// File: logic/execute_stage.sv
// condition check, alu and flag register, writes the bank and reports each completed instruction
`timescale 1ns/1ps

module execute_stage (
    input  logic                    clk,
    input  logic                    i_reset_n,
    decoded_if.exe_in               i_dec,
    reg_if.user                     io_rf,
    output logic                    o_wb_valid,
    output logic                    o_wb_en,
    output arm_lite_pkg::reg_addr_t o_wb_addr,
    output arm_lite_pkg::word_t     o_wb_data,
    output arm_lite_pkg::nzcv_t     o_nzcv
);
    import arm_lite_pkg::*;

    nzcv_t flags_q;
    nzcv_t flags_d;
    word_t op_a;
    word_t op_b;
    word_t alu_res;
    logic  carry;
    logic  ovf;
    logic  do_exec;  // valid and condition passed
    logic  wr_en;

    function automatic logic check_cond(input cond_e cond, input nzcv_t f);
        logic n;
        logic z;
        logic c;
        logic v;
        {n, z, c, v} = f;
        case (cond)
            COND_EQ: return z;
            COND_NE: return !z;
            COND_CS: return c;
            COND_CC: return !c;
            COND_MI: return n;
            COND_PL: return !n;
            COND_VS: return v;
            COND_VC: return !v;
            COND_HI: return c && !z;
            COND_LS: return !c || z;
            COND_GE: return n == v;
            COND_LT: return n != v;
            COND_GT: return !z && (n == v);
            COND_LE: return z || (n != v);
            COND_AL: return 1'b1;
            default: return 1'b0;  // nv never executes
        endcase
    endfunction

    assign io_rf.rd_addr_a = i_dec.rn;
    assign io_rf.rd_addr_b = i_dec.op2.rm;
    assign op_a            = io_rf.rd_data_a;

    operand2_shifter u_operand2_shifter (
        .i_op2   (i_dec.op2),
        .i_rm_val(io_rf.rd_data_b),
        .o_value (op_b)
    );

    always_comb begin
        carry   = flags_q[1];  // logical ops keep c and v
        ovf     = flags_q[0];
        alu_res = op_b;
        case (i_dec.alu_op)
            ALU_PASS_B: alu_res = op_b;
            ALU_NOT_B:  alu_res = ~op_b;
            ALU_ADD: begin
                {carry, alu_res} = {1'b0, op_a} + {1'b0, op_b};
                ovf = (op_a[XLEN-1] == op_b[XLEN-1]) && (alu_res[XLEN-1] != op_a[XLEN-1]);
            end
            ALU_SUB: begin
                // c set means no borrow
                {carry, alu_res} = {1'b0, op_a} + {1'b0, ~op_b} + (XLEN+1)'(1);
                ovf = (op_a[XLEN-1] != op_b[XLEN-1]) && (alu_res[XLEN-1] != op_a[XLEN-1]);
            end
            ALU_AND: alu_res = op_a & op_b;
            ALU_ORR: alu_res = op_a | op_b;
            ALU_EOR: alu_res = op_a ^ op_b;
            default: alu_res = op_b;
        endcase
    end

    assign flags_d = {alu_res[XLEN-1], alu_res == '0, carry, ovf};
    assign do_exec = i_dec.valid && check_cond(i_dec.cond, flags_q);
    assign wr_en   = do_exec && i_dec.wb_en;

    assign io_rf.wr_en   = wr_en;
    assign io_rf.wr_addr = i_dec.rd;
    assign io_rf.wr_data = alu_res;

    always_ff @(posedge clk) begin
        if (!i_reset_n) begin
            flags_q    <= '0;
            o_wb_valid <= 1'b0;
            o_wb_en    <= 1'b0;
        end else begin
            o_wb_valid <= i_dec.valid;  // every instruction completes
            o_wb_en    <= wr_en;
            if (do_exec && i_dec.set_flags) begin
                flags_q <= flags_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_dec.valid) begin
            o_wb_addr <= i_dec.rd;
            o_wb_data <= alu_res;
        end
    end

    assign o_nzcv = flags_q;
endmodule

// File: logic/ins_decoder.sv
// registers each strobed instruction and splits it into the decoded operation for execute
`timescale 1ns/1ps

module ins_decoder (
    input  logic                clk,
    input  logic                i_reset_n,
    input  logic                i_ins_valid,
    input  arm_lite_pkg::word_t i_ins,
    decoded_if.dec_out          o_dec
);
    import arm_lite_pkg::*;

    dp_op_e    opc;
    alu_op_e   alu_op;
    logic      is_dp;       // data-processing with a supported operand form
    logic      known_op;
    logic      is_compare;  // cmp and tst
    operand2_t op2;

    assign opc   = dp_op_e'(i_ins[OPC_LSB +: 4]);
    assign is_dp = (i_ins[TYPE_LSB +: 2] == 2'b00) &&
                   (i_ins[IMM_BIT] || !i_ins[REG_SHIFT_BIT]);

    always_comb begin
        known_op   = 1'b1;
        is_compare = 1'b0;
        alu_op     = ALU_PASS_B;
        case (opc)
            OP_MOV: alu_op = ALU_PASS_B;
            OP_MVN: alu_op = ALU_NOT_B;
            OP_ADD: alu_op = ALU_ADD;
            OP_SUB: alu_op = ALU_SUB;
            OP_AND: alu_op = ALU_AND;
            OP_ORR: alu_op = ALU_ORR;
            OP_EOR: alu_op = ALU_EOR;
            OP_CMP: begin
                alu_op     = ALU_SUB;
                is_compare = 1'b1;
            end
            OP_TST: begin
                alu_op     = ALU_AND;
                is_compare = 1'b1;
            end
            default: known_op = 1'b0;  // rsb, adc, sbc, teq and the rest
        endcase
    end

    always_comb begin
        op2.is_imm = i_ins[IMM_BIT];
        op2.imm8   = i_ins[IMM8_LSB +: 8];
        op2.rot4   = i_ins[ROT_LSB +: 4];
        op2.sh     = shift_e'(i_ins[SHIFT_LSB +: 2]);
        op2.shamt5 = i_ins[SHAMT_LSB +: 5];
        op2.rm     = i_ins[RM_LSB +: REG_ADDR_W];
    end

    always_ff @(posedge clk) begin
        if (!i_reset_n) begin
            o_dec.valid <= 1'b0;
        end else begin
            o_dec.valid <= i_ins_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ins_valid) begin
            o_dec.cond      <= cond_e'(i_ins[COND_LSB +: 4]);
            o_dec.alu_op    <= alu_op;
            o_dec.wb_en     <= is_dp && known_op && !is_compare;
            o_dec.set_flags <= is_dp && known_op && (i_ins[S_BIT] || is_compare);
            o_dec.rd        <= i_ins[RD_LSB +: REG_ADDR_W];
            o_dec.rn        <= i_ins[RN_LSB +: REG_ADDR_W];
            o_dec.op2       <= op2;
        end
    end
endmodule

// File: logic/operand2_shifter.sv
// builds the second alu operand from the rotated immediate or the shifted rm value
`timescale 1ns/1ps

module operand2_shifter (
    input  arm_lite_pkg::operand2_t i_op2,
    input  arm_lite_pkg::word_t     i_rm_val,
    output arm_lite_pkg::word_t     o_value
);
    import arm_lite_pkg::*;

    word_t imm_value;
    word_t reg_value;

    function automatic word_t rotate_right(input word_t value, input logic [4:0] amount);
        logic [2*XLEN-1:0] doubled;
        doubled = {value, value} >> amount;
        return doubled[XLEN-1:0];
    endfunction

    // imm8 rotated right by 2 * rot4
    assign imm_value = rotate_right({{(XLEN-8){1'b0}}, i_op2.imm8}, {i_op2.rot4, 1'b0});

    always_comb begin
        reg_value = i_rm_val;
        case (i_op2.sh)
            SH_LSL: reg_value = i_rm_val << i_op2.shamt5;
            SH_LSR: reg_value = i_rm_val >> i_op2.shamt5;
            SH_ASR: reg_value = word_t'($signed(i_rm_val) >>> i_op2.shamt5);
            SH_ROR: reg_value = rotate_right(i_rm_val, i_op2.shamt5);
            default: reg_value = i_rm_val;
        endcase
    end

    assign o_value = i_op2.is_imm ? imm_value : reg_value;
endmodule

// File: logic/reg_bank.sv
// sixteen general registers with two combinational reads and one clocked write port
`timescale 1ns/1ps

module reg_bank (
    input  logic clk,
    input  logic i_reset_n,
    reg_if.bank  io_rf
);
    import arm_lite_pkg::*;

    word_t regs [NUM_REGS];

    // reads see the old value during a write cycle
    assign io_rf.rd_data_a = regs[io_rf.rd_addr_a];
    assign io_rf.rd_data_b = regs[io_rf.rd_addr_b];

    always_ff @(posedge clk) begin
        if (!i_reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (io_rf.wr_en) begin
            regs[io_rf.wr_addr] <= io_rf.wr_data;
        end
    end
endmodule

// File: logic/reg_if.sv
// register bank access between the execute stage and the bank, two reads and one write
`timescale 1ns/1ps

interface reg_if ();
    import arm_lite_pkg::*;

    reg_addr_t rd_addr_a;  // rn
    word_t     rd_data_a;
    reg_addr_t rd_addr_b;  // rm
    word_t     rd_data_b;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    modport user (
        output rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
        input  rd_data_a, rd_data_b
    );

    modport bank (
        input  rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
        output rd_data_a, rd_data_b
    );
endinterface

// File: sim/tb_model.svh
// reference model of operand2, alu, flags and conditions, included inside the testbench module
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic logic [31:0] rotate_word(input logic [31:0] value, input logic [4:0] amount);
    return (value >> amount) | (value << (6'd32 - {1'b0, amount}));  // amount 0 keeps value
endfunction

function automatic logic [31:0] operand2_value(input logic [31:0] word,
                                               input logic [31:0] rm_val);
    logic [4:0] shamt;
    shamt = word[11:7];
    if (word[25]) begin
        return rotate_word({24'd0, word[7:0]}, {word[11:8], 1'b0});
    end
    case (word[6:5])
        2'd0:    return rm_val << shamt;
        2'd1:    return rm_val >> shamt;
        2'd2:    return 32'($signed(rm_val) >>> shamt);
        default: return rotate_word(rm_val, shamt);
    endcase
endfunction

function automatic logic is_supported(input logic [3:0] opc);
    case (opc)
        4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'hA, 4'hC, 4'hD, 4'hF: return 1'b1;
        default: return 1'b0;  // rsb, adc, sbc, teq, cmn, bic
    endcase
endfunction

function automatic void alu_compute(input logic [3:0] opc, input logic [31:0] a,
                                    input logic [31:0] b, input logic [3:0] flags_in,
                                    output logic [31:0] res, output logic [3:0] flags_out);
    logic [32:0] wide;
    logic        c;
    logic        v;
    c    = flags_in[1];  // kept by logical ops
    v    = flags_in[0];
    wide = 33'd0;
    case (opc)
        4'h4: begin
            res  = a + b;
            c    = (res < a);  // unsigned wrap means carry out
            wide = {a[31], a} + {b[31], b};
            v    = (wide[32] != wide[31]);  // signed sum does not fit
        end
        4'h2, 4'hA: begin
            res  = a - b;
            c    = (a >= b);  // no borrow
            wide = {a[31], a} - {b[31], b};
            v    = (wide[32] != wide[31]);
        end
        4'h0, 4'h8: res = a & b;
        4'hC:       res = a | b;
        4'h1:       res = a ^ b;
        4'hF:       res = ~b;
        default:    res = b;
    endcase
    flags_out = {res[31], res == 32'd0, c, v};
endfunction

function automatic logic cond_passes(input logic [3:0] cond, input logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cond)
        4'h0:    return z;
        4'h1:    return !z;
        4'h2:    return c;
        4'h3:    return !c;
        4'h4:    return n;
        4'h5:    return !n;
        4'h6:    return v;
        4'h7:    return !v;
        4'h8:    return c && !z;
        4'h9:    return !c || z;
        4'hA:    return n == v;
        4'hB:    return n != v;
        4'hC:    return !z && (n == v);
        4'hD:    return z || (n != v);
        4'hE:    return 1'b1;
        default: return 1'b0;
    endcase
endfunction

`endif

// File: sim/tb_arm_lite_core.sv
// directed testbench for the arm lite core, every writeback is checked against a shadow model
`timescale 1ns/1ps

module tb_arm_lite_core;
    localparam logic [3:0] AL  = 4'hE;
    localparam logic [3:0] MOV = 4'hD;
    localparam logic [3:0] MVN = 4'hF;
    localparam logic [3:0] ADD = 4'h4;
    localparam logic [3:0] SUB = 4'h2;
    localparam logic [3:0] AND = 4'h0;
    localparam logic [3:0] ORR = 4'hC;
    localparam logic [3:0] EOR = 4'h1;
    localparam logic [3:0] CMP = 4'hA;
    localparam logic [3:0] TST = 4'h8;

    logic        clk;
    logic        reset_n;
    logic        ins_valid;
    logic [31:0] ins;
    logic        wb_valid;
    logic        wb_en;
    logic [3:0]  wb_addr;
    logic [31:0] wb_data;
    logic [3:0]  nzcv;

    logic [31:0] shadow_regs [16];
    logic [3:0]  shadow_flags;
    integer      seed;
    int          error_count;

    `include "tb_model.svh"

    arm_lite_core i_arm_lite_core (
        .clk        (clk),
        .i_reset_n  (reset_n),
        .i_ins_valid(ins_valid),
        .i_ins      (ins),
        .o_wb_valid (wb_valid),
        .o_wb_en    (wb_en),
        .o_wb_addr  (wb_addr),
        .o_wb_data  (wb_data),
        .o_nzcv     (nzcv)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] dp_imm(input logic [3:0] cond, input logic [3:0] opc,
                                           input logic s, input logic [3:0] rn,
                                           input logic [3:0] rd, input logic [3:0] rot,
                                           input logic [7:0] imm8);
        return {cond, 2'b00, 1'b1, opc, s, rn, rd, rot, imm8};
    endfunction

    function automatic logic [31:0] dp_reg(input logic [3:0] cond, input logic [3:0] opc,
                                           input logic s, input logic [3:0] rn,
                                           input logic [3:0] rd, input logic [4:0] shamt,
                                           input logic [1:0] sh, input logic [3:0] rm);
        return {cond, 2'b00, 1'b0, opc, s, rn, rd, shamt, sh, 1'b0, rm};
    endfunction

    task automatic step();
        @(posedge clk);
        #2;  // drive and sample point
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // runs the shadow model for one instruction and updates its state
    task automatic predict(input logic [31:0] word, output logic exp_en, output logic known,
                           output logic [31:0] exp_data);
        logic        compare;
        logic        passes;
        logic [31:0] b;
        logic [3:0]  new_flags;
        known   = (word[27:26] == 2'b00) && (word[25] || !word[4]) && is_supported(word[24:21]);
        compare = (word[24:21] == TST) || (word[24:21] == CMP);
        b       = operand2_value(word, shadow_regs[word[3:0]]);
        alu_compute(word[24:21], shadow_regs[word[19:16]], b, shadow_flags, exp_data, new_flags);
        passes  = cond_passes(word[31:28], shadow_flags);
        exp_en  = known && passes && !compare;
        if (exp_en) begin
            shadow_regs[word[15:12]] = exp_data;
        end
        if (known && passes && (word[20] || compare)) begin
            shadow_flags = new_flags;
        end
    endtask

    task automatic check_wb(input logic [31:0] word, input logic exp_en, input logic known,
                            input logic [31:0] exp_data, input logic [3:0] exp_flags);
        check_value("o_wb_valid", 32'(wb_valid), 32'd1);
        check_value("o_wb_en", 32'(wb_en), 32'(exp_en));
        check_value("o_wb_addr", 32'(wb_addr), 32'(word[15:12]));
        if (known) begin
            check_value("o_wb_data", wb_data, exp_data);  // no-op data is undefined
        end
        check_value("o_nzcv", 32'(nzcv), 32'(exp_flags));
    endtask

    task automatic run_ins(input logic [31:0] word);
        logic        exp_en;
        logic        known;
        logic [31:0] exp_data;
        int          cycles;
        predict(word, exp_en, known, exp_data);
        ins       = word;
        ins_valid = 1'b1;
        step();
        ins_valid = 1'b0;
        cycles    = 1;
        while (!wb_valid) begin
            if (cycles >= 20) begin
                $display("** Error at %0t ns: no writeback strobe within 20 cycles", $time);
                $display("Some tests failed");
                $fatal(1, "writeback timeout");
            end
            step();
            cycles++;
        end
        check_value("writeback latency", 32'(cycles), 32'd2);
        check_wb(word, exp_en, known, exp_data, shadow_flags);
    endtask

    // two strobes on consecutive cycles, each reported two cycles later
    task automatic run_pair(input logic [31:0] first, input logic [31:0] second);
        logic        en_a;
        logic        known_a;
        logic [31:0] data_a;
        logic [3:0]  flags_a;
        logic        en_b;
        logic        known_b;
        logic [31:0] data_b;
        predict(first, en_a, known_a, data_a);
        flags_a = shadow_flags;
        predict(second, en_b, known_b, data_b);
        ins       = first;
        ins_valid = 1'b1;
        step();
        check_value("o_wb_valid", 32'(wb_valid), 32'd0);
        ins = second;
        step();
        ins_valid = 1'b0;
        check_wb(first, en_a, known_a, data_a, flags_a);
        step();
        check_wb(second, en_b, known_b, data_b, shadow_flags);
    endtask

    // builds any 32-bit value from one mov and three rotated orr
    task automatic load_reg(input logic [3:0] rd, input logic [31:0] value);
        run_ins(dp_imm(AL, MOV, 1'b0, 4'd0, rd, 4'd0, value[7:0]));
        run_ins(dp_imm(AL, ORR, 1'b0, rd, rd, 4'd12, value[15:8]));
        run_ins(dp_imm(AL, ORR, 1'b0, rd, rd, 4'd8, value[23:16]));
        run_ins(dp_imm(AL, ORR, 1'b0, rd, rd, 4'd4, value[31:24]));
    endtask

    task automatic test_moves();
        for (int r = 0; r < 8; r++) begin
            run_ins(dp_imm(AL, MOV, 1'b0, 4'd0, 4'(r), 4'(r * 2), 8'($random(seed))));
        end
        run_ins(dp_imm(AL, MVN, 1'b1, 4'd0, 4'd8, 4'd3, 8'hA5));
        run_ins(dp_imm(AL, MOV, 1'b1, 4'd0, 4'd9, 4'd0, 8'd0));  // z set
    endtask

    task automatic arith_round(input logic [31:0] a, input logic [31:0] b);
        load_reg(4'd1, a);
        load_reg(4'd2, b);
        run_ins(dp_reg(AL, ADD, 1'b1, 4'd1, 4'd3, 5'd0, 2'd0, 4'd2));
        run_ins(dp_reg(AL, SUB, 1'b1, 4'd1, 4'd3, 5'd0, 2'd0, 4'd2));
        run_ins(dp_reg(AL, AND, 1'b1, 4'd1, 4'd3, 5'd0, 2'd0, 4'd2));
        run_ins(dp_reg(AL, ORR, 1'b1, 4'd1, 4'd3, 5'd0, 2'd0, 4'd2));
        run_ins(dp_reg(AL, EOR, 1'b1, 4'd1, 4'd3, 5'd0, 2'd0, 4'd2));
    endtask

    task automatic test_arith();
        arith_round(32'h7FFF_FFFF, 32'd1);  // signed overflow on add
        arith_round(32'h8000_0000, 32'd1);  // signed overflow on sub
        arith_round(32'hFFFF_FFFF, 32'd1);  // carry out
        arith_round(32'd5, 32'd7);          // borrow
        repeat (6) begin
            arith_round($random(seed), $random(seed));
        end
    endtask

    task automatic test_shifts();
        repeat (4) begin
            load_reg(4'd4, $random(seed));
            for (int sh = 0; sh < 4; sh++) begin
                run_ins(dp_reg(AL, MOV, 1'b1, 4'd0, 4'd5, 5'($random(seed)), 2'(sh), 4'd4));
            end
        end
    endtask

    task automatic cond_sweep(input logic [31:0] compare_word);
        run_ins(compare_word);
        for (int c = 0; c < 16; c++) begin
            run_ins(dp_imm(4'(c), MOV, 1'b0, 4'd0, 4'd6, 4'd0, 8'(c + 1)));  // nv at 15
        end
    endtask

    task automatic test_conditions();
        load_reg(4'd1, 32'd5);
        load_reg(4'd2, 32'd5);
        cond_sweep(dp_reg(AL, CMP, 1'b0, 4'd1, 4'd0, 5'd0, 2'd0, 4'd2));
        load_reg(4'd2, 32'd7);
        cond_sweep(dp_reg(AL, CMP, 1'b0, 4'd1, 4'd0, 5'd0, 2'd0, 4'd2));
        load_reg(4'd1, 32'h8000_0000);
        load_reg(4'd2, 32'd1);
        cond_sweep(dp_reg(AL, CMP, 1'b0, 4'd1, 4'd0, 5'd0, 2'd0, 4'd2));
        cond_sweep(dp_reg(AL, TST, 1'b0, 4'd1, 4'd0, 5'd0, 2'd0, 4'd2));
        cond_sweep(dp_reg(AL, TST, 1'b0, 4'd1, 4'd0, 5'd0, 2'd0, 4'd1));
        repeat (3) begin
            load_reg(4'd1, $random(seed));
            load_reg(4'd2, $random(seed));
            cond_sweep(dp_reg(AL, CMP, 1'b0, 4'd1, 4'd0, 5'd0, 2'd0, 4'd2));
        end
    endtask

    task automatic test_timing_noops();
        logic [3:0] flags_before;
        run_pair(dp_imm(AL, MOV, 1'b0, 4'd0, 4'd7, 4'd0, 8'd21),
                 dp_reg(AL, ADD, 1'b1, 4'd7, 4'd8, 5'd1, 2'd0, 4'd7));
        run_pair(dp_reg(AL, ADD, 1'b0, 4'd7, 4'd9, 5'd0, 2'd0, 4'd8),
                 dp_reg(AL, SUB, 1'b1, 4'd7, 4'd10, 5'd0, 2'd0, 4'd9));
        flags_before = shadow_flags;
        run_ins(32'hE591_3000);  // ldr r3, [r1]
        check_value("o_nzcv", 32'(nzcv), 32'(flags_before));
        run_ins(dp_reg(AL, ADD, 1'b1, 4'd1, 4'd3, 5'd0, 2'd0, 4'd2) | 32'h0000_0210);
        run_ins(dp_reg(AL, 4'h3, 1'b1, 4'd1, 4'd3, 5'd0, 2'd0, 4'd2));  // rsb
    endtask

    initial begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        ins_valid    = 1'b0;
        ins          = 32'd0;
        seed         = 82;
        error_count  = 0;
        shadow_flags = 4'd0;
        for (int i = 0; i < 16; i++) begin
            shadow_regs[i] = 32'd0;
        end
        repeat (10) @(posedge clk);
        #2;
        reset_n = 1'b1;
        check_value("o_wb_valid", 32'(wb_valid), 32'd0);
        check_value("o_nzcv", 32'(nzcv), 32'd0);
        test_moves();
        test_arith();
        test_shifts();
        test_conditions();
        test_timing_noops();
        step();
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end
endmodule
